// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ns
TOP = tb_soc_bus_fabric
FILELIST = files.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== files.f ====
hdl/soc_bus_pkg.sv
hdl/mem_bus_if.sv
hdl/mem_arbiter.sv
hdl/mem_region_decode.sv
hdl/onchip_ram.sv
hdl/io_port_decode.sv
hdl/soc_bus_fabric.sv
tb/soc_bus_fabric_sva.sv
tb/tb_soc_bus_fabric.sv

// ==== hdl/io_port_decode.sv ====
// I/O port decoder holding the LED and BIOS control registers, acks unknown ports with zero
`default_nettype none
`timescale 1ns/1ns

module io_port_decode #(
    parameter int num_leds = 8
) (
    input wire sys_clk,
    input wire reset,
    input wire access,
    input wire soc_bus_pkg::word_addr_t addr,
    input wire soc_bus_pkg::bus_data_t wdata,
    input wire wr_en,
    input wire soc_bus_pkg::bytesel_t bytesel,
    output soc_bus_pkg::bus_data_t rdata,
    output logic ack,
    output logic [num_leds-1:0] leds,
    output logic bios_enabled
);

    soc_bus_pkg::io_port_t port;
    soc_bus_pkg::bus_data_t rdata_r;
    soc_bus_pkg::bus_data_t read_val;
    logic leds_sel;
    logic bios_ctrl_sel;
    logic fresh;
    logic lane_write;
    logic ack_r;

    assign port = {addr[15:1], 1'b0};
    assign leds_sel = port == soc_bus_pkg::leds_port;
    assign bios_ctrl_sel = port == soc_bus_pkg::bios_ctrl_port;

    assign fresh = access & ~ack_r;
    assign lane_write = fresh & wr_en & bytesel[0];   // Registers live in the low byte

    always_comb begin
        if (leds_sel)
            read_val = soc_bus_pkg::bus_data_t'(leds);
        else if (bios_ctrl_sel)
            read_val = soc_bus_pkg::bus_data_t'(bios_enabled);
        else
            read_val = '0;                              // Default responder
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            ack_r <= 1'b0;
            leds <= '0;
            bios_enabled <= 1'b1;                        // Boot from BIOS
        end else begin
            ack_r <= fresh;
            if (lane_write && leds_sel)
                leds <= wdata[num_leds-1:0];
            if (lane_write && bios_ctrl_sel)
                bios_enabled <= wdata[0];
        end
    end

    always_ff @(posedge sys_clk) begin
        if (fresh)
            rdata_r <= read_val;
    end

    assign ack = ack_r;
    assign rdata = rdata_r;

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
// Fixed-priority arbiter sharing one memory bus between the data and instruction buses
`default_nettype none
`timescale 1ns/1ns

module mem_arbiter (
    input wire sys_clk,
    input wire reset,
    mem_bus_if.responder instr_bus,
    mem_bus_if.responder data_bus,
    mem_bus_if.requester shared_bus
);

    soc_bus_pkg::arb_state_e state;
    soc_bus_pkg::arb_state_e next_state;
    logic serve_data;
    logic serve_instr;

    assign serve_data = state == soc_bus_pkg::arb_serve_data;
    assign serve_instr = state == soc_bus_pkg::arb_serve_instr;

    always_comb begin
        next_state = state;
        case (state)
            soc_bus_pkg::arb_idle: begin
                if (data_bus.access)         // Data wins a tie
                    next_state = soc_bus_pkg::arb_serve_data;
                else if (instr_bus.access)
                    next_state = soc_bus_pkg::arb_serve_instr;
            end
            soc_bus_pkg::arb_serve_data,
            soc_bus_pkg::arb_serve_instr: begin
                if (shared_bus.ack)
                    next_state = soc_bus_pkg::arb_idle;
            end
            default: next_state = soc_bus_pkg::arb_idle;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (reset)
            state <= soc_bus_pkg::arb_idle;
        else
            state <= next_state;
    end

    // Forward the granted requester
    always_comb begin
        shared_bus.access = (serve_data & data_bus.access) |
                            (serve_instr & instr_bus.access);
        if (serve_instr) begin
            shared_bus.addr = instr_bus.addr;
            shared_bus.wdata = instr_bus.wdata;
            shared_bus.wr_en = 1'b0;         // Fetches are always full-word reads
            shared_bus.bytesel = 2'b11;
        end else begin
            shared_bus.addr = data_bus.addr;
            shared_bus.wdata = data_bus.wdata;
            shared_bus.wr_en = data_bus.wr_en;
            shared_bus.bytesel = data_bus.bytesel;
        end
    end

    // Response goes back to the granted side only
    assign data_bus.ack = serve_data & shared_bus.ack;
    assign instr_bus.ack = serve_instr & shared_bus.ack;
    assign data_bus.rdata = serve_data ? shared_bus.rdata : '0;
    assign instr_bus.rdata = serve_instr ? shared_bus.rdata : '0;

endmodule

`default_nettype wire

// ==== hdl/mem_bus_if.sv ====
// One memory bus with the hold-until-ack handshake, used between fabric blocks
`default_nettype none
`timescale 1ns/1ns

interface mem_bus_if;

    soc_bus_pkg::word_addr_t addr;
    soc_bus_pkg::bus_data_t wdata;
    soc_bus_pkg::bus_data_t rdata;   // Valid in the ack cycle only
    logic access;                    // Held until ack
    logic ack;                       // One-cycle pulse
    logic wr_en;
    soc_bus_pkg::bytesel_t bytesel;

    modport requester (
        output addr, wdata, access, wr_en, bytesel,
        input rdata, ack
    );

    modport responder (
        input addr, wdata, access, wr_en, bytesel,
        output rdata, ack
    );

endinterface

`default_nettype wire

// ==== hdl/mem_region_decode.sv ====
// Routes the arbitrated memory bus to the BIOS RAM or main RAM and merges the replies
`default_nettype none
`timescale 1ns/1ns

module mem_region_decode #(
    parameter int bios_words = 8192
) (
    input wire bios_enabled,
    mem_bus_if.responder shared_bus,
    mem_bus_if.requester bios_bus,
    mem_bus_if.requester ram_bus
);

    localparam int bios_bits = $clog2(bios_words);
    localparam int tag_bits = $bits(soc_bus_pkg::bios_window_tag);

    logic in_window;
    logic bios_sel;

    assign in_window = shared_bus.addr[19 -: tag_bits] == soc_bus_pkg::bios_window_tag;
    assign bios_sel = bios_enabled & in_window;

    assign bios_bus.access = shared_bus.access & bios_sel;
    assign bios_bus.addr = soc_bus_pkg::word_addr_t'(shared_bus.addr[bios_bits:1]);
    assign bios_bus.wdata = shared_bus.wdata;
    assign bios_bus.wr_en = shared_bus.wr_en;
    assign bios_bus.bytesel = shared_bus.bytesel;

    assign ram_bus.access = shared_bus.access & ~bios_sel;
    assign ram_bus.addr = shared_bus.addr;          // RAM wraps it by its own size
    assign ram_bus.wdata = shared_bus.wdata;
    assign ram_bus.wr_en = shared_bus.wr_en;
    assign ram_bus.bytesel = shared_bus.bytesel;

    // Pick read data by who acked, so a BIOS toggle mid-access stays consistent
    assign shared_bus.ack = bios_bus.ack | ram_bus.ack;
    assign shared_bus.rdata = bios_bus.ack ? bios_bus.rdata : ram_bus.rdata;

endmodule

`default_nettype wire

// ==== hdl/onchip_ram.sv ====
// Word RAM with byte-lane writes and a registered ack, used for both BIOS and main memory
`default_nettype none
`timescale 1ns/1ns

module onchip_ram #(
    parameter int words = 4096
) (
    input wire sys_clk,
    input wire reset,
    mem_bus_if.responder bus
);

    localparam int addr_bits = $clog2(words);

    soc_bus_pkg::bus_data_t mem [words];
    soc_bus_pkg::bus_data_t rdata_r;
    logic [addr_bits-1:0] index;
    logic ack_r;
    logic fresh;

    assign index = bus.addr[addr_bits:1];   // Address modulo words
    assign fresh = bus.access & ~ack_r;     // Not yet acked

    always_ff @(posedge sys_clk) begin
        if (reset)
            ack_r <= 1'b0;
        else
            ack_r <= fresh;
    end

    always_ff @(posedge sys_clk) begin
        if (fresh) begin
            rdata_r <= mem[index];
            if (bus.wr_en && bus.bytesel[0])
                mem[index][7:0] <= bus.wdata[7:0];
            if (bus.wr_en && bus.bytesel[1])
                mem[index][15:8] <= bus.wdata[15:8];
        end
    end

    assign bus.ack = ack_r;
    assign bus.rdata = rdata_r;

endmodule

`default_nettype wire

// ==== hdl/soc_bus_fabric.sv ====
// Bus fabric top level joining the CPU instruction and data buses to I/O and memories
`default_nettype none
`timescale 1ns/1ns

module soc_bus_fabric #(
    parameter int ram_words = 4096,
    parameter int bios_words = 8192,
    parameter int num_leds = 8
) (
    input wire sys_clk,
    input wire reset,
    input wire soc_bus_pkg::word_addr_t instr_addr,
    input wire instr_access,
    output soc_bus_pkg::bus_data_t instr_rdata,
    output logic instr_ack,
    input wire soc_bus_pkg::word_addr_t data_addr,
    input wire soc_bus_pkg::bus_data_t data_wdata,
    input wire data_access,
    input wire data_wr_en,
    input wire soc_bus_pkg::bytesel_t data_bytesel,
    input wire io,
    output soc_bus_pkg::bus_data_t data_rdata,
    output logic data_ack,
    output logic [num_leds-1:0] leds
);

    mem_bus_if instr_bus ();
    mem_bus_if data_bus ();
    mem_bus_if shared_bus ();
    mem_bus_if bios_bus ();
    mem_bus_if ram_bus ();

    soc_bus_pkg::bus_data_t io_rdata;
    logic io_ack;
    logic bios_enabled;

    // Instruction side is fetch only
    assign instr_bus.addr = instr_addr;
    assign instr_bus.access = instr_access;
    assign instr_bus.wdata = '0;
    assign instr_bus.wr_en = 1'b0;
    assign instr_bus.bytesel = 2'b11;
    assign instr_rdata = instr_bus.rdata;
    assign instr_ack = instr_bus.ack;

    assign data_bus.addr = data_addr;
    assign data_bus.access = data_access & ~io;    // Memory half of the data bus
    assign data_bus.wdata = data_wdata;
    assign data_bus.wr_en = data_wr_en;
    assign data_bus.bytesel = data_bytesel;

    assign data_rdata = io ? io_rdata : data_bus.rdata;
    assign data_ack = io ? io_ack : data_bus.ack;

    mem_arbiter i_arbiter (.sys_clk, .reset, .instr_bus, .data_bus, .shared_bus);

    mem_region_decode #(.bios_words(bios_words)) i_region_decode (
        .bios_enabled, .shared_bus, .bios_bus, .ram_bus
    );

    onchip_ram #(.words(bios_words)) bios_ram (.sys_clk, .reset, .bus(bios_bus));
    onchip_ram #(.words(ram_words)) main_ram (.sys_clk, .reset, .bus(ram_bus));

    io_port_decode #(.num_leds(num_leds)) i_io_decode (
        .sys_clk, .reset,
        .access(data_access & io),
        .addr(data_addr), .wdata(data_wdata), .wr_en(data_wr_en), .bytesel(data_bytesel),
        .rdata(io_rdata), .ack(io_ack), .leds, .bios_enabled
    );

endmodule

`default_nettype wire

// ==== hdl/soc_bus_pkg.sv ====
// Shared bus widths, I/O port map and arbiter state, referenced by scoped names
`default_nettype none

package soc_bus_pkg;

    // Word address, byte address bit 0 is implied by bytesel
    typedef logic [19:1] word_addr_t;

    typedef logic [15:0] bus_data_t;

    // Bit 0 selects the low byte
    typedef logic [1:0] bytesel_t;

    // I/O port byte address
    typedef logic [15:0] io_port_t;

    localparam io_port_t leds_port = 16'hfffe;
    localparam io_port_t bios_ctrl_port = 16'hffec;

    // Top address bits of the BIOS window FC000-FFFFF
    localparam logic [5:0] bios_window_tag = 6'b111111;

    // Memory arbiter grant state
    typedef enum logic [1:0] {
        arb_idle,
        arb_serve_data,
        arb_serve_instr
    } arb_state_e;

endpackage

`default_nettype wire

// ==== tb/soc_bus_fabric_sva.sv ====
// Handshake assertions on the CPU-side buses, bound into the fabric top level
`default_nettype none
`timescale 1ns/1ns

module soc_bus_fabric_sva (
    input wire sys_clk,
    input wire reset,
    input wire instr_access,
    input wire instr_ack,
    input wire data_access,
    input wire data_ack
);

    acks_exclusive: assert property (@(posedge sys_clk) disable iff (reset)
        !(instr_ack && data_ack)) else $error("instr_ack and data_ack high together");

    // Ack only answers a held request
    instr_ack_held: assert property (@(posedge sys_clk) disable iff (reset)
        instr_ack |-> instr_access) else $error("instr_ack without instr_access");
    data_ack_held: assert property (@(posedge sys_clk) disable iff (reset)
        data_ack |-> data_access) else $error("data_ack without data_access");

    instr_ack_pulse: assert property (@(posedge sys_clk) disable iff (reset)
        instr_ack |=> !instr_ack) else $error("instr_ack high two cycles in a row");
    data_ack_pulse: assert property (@(posedge sys_clk) disable iff (reset)
        data_ack |=> !data_ack) else $error("data_ack high two cycles in a row");

endmodule

bind soc_bus_fabric soc_bus_fabric_sva i_sva (
    .sys_clk, .reset, .instr_access, .instr_ack, .data_access, .data_ack
);

`default_nettype wire

// ==== tb/tb_soc_bus_fabric.sv ====
// Random-stimulus testbench for the bus fabric, checks memory and I/O reads against a model
`default_nettype none
`timescale 1ns/1ns

module tb_soc_bus_fabric;

    localparam int ram_words = 4096;
    localparam int bios_words = 8192;
    localparam int num_leds = 8;
    localparam int timeout_cycles = 6000;             // 600 transactions of 10 cycles

    logic sys_clk;
    logic reset;
    soc_bus_pkg::word_addr_t instr_addr;
    logic instr_access;
    soc_bus_pkg::bus_data_t instr_rdata;
    logic instr_ack;
    soc_bus_pkg::word_addr_t data_addr;
    soc_bus_pkg::bus_data_t data_wdata;
    logic data_access;
    logic data_wr_en;
    soc_bus_pkg::bytesel_t data_bytesel;
    logic io;
    soc_bus_pkg::bus_data_t data_rdata;
    logic data_ack;
    logic [num_leds-1:0] leds;

    // Model state
    soc_bus_pkg::bus_data_t ram_m [ram_words];
    soc_bus_pkg::bytesel_t ram_known [ram_words];     // Lanes written so far
    soc_bus_pkg::bus_data_t bios_m [bios_words];
    soc_bus_pkg::bytesel_t bios_known [bios_words];
    logic [num_leds-1:0] leds_m;
    logic bios_en_m;
    integer seed = 1;
    int cycles = 0;

    soc_bus_fabric #(
        .ram_words(ram_words), .bios_words(bios_words), .num_leds(num_leds)
    ) i_dut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("Timeout: a bus request got no ack within %0d cycles", timeout_cycles);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic check(input string name, input soc_bus_pkg::bus_data_t expected,
                         input soc_bus_pkg::bus_data_t actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    // FC000-FFFFF goes to BIOS only while it is enabled
    function automatic logic to_bios(input soc_bus_pkg::word_addr_t a);
        return bios_en_m && a[19:14] == 6'b111111;
    endfunction

    function automatic soc_bus_pkg::word_addr_t rand_addr(input logic bios_region);
        logic [31:0] r;
        soc_bus_pkg::word_addr_t a;
        r = $random(seed);
        a = soc_bus_pkg::word_addr_t'(r & 32'h0007_e03f);   // Random tag, 64-word pool
        if (bios_region)
            a[19:14] = 6'b111111;
        else
            a[19] = 1'b0;
        return a;
    endfunction

    function automatic soc_bus_pkg::bus_data_t lane_mask(input soc_bus_pkg::bytesel_t k);
        return {{8{k[1]}}, {8{k[0]}}};
    endfunction

    task automatic model_lookup(input soc_bus_pkg::word_addr_t a,
                                output soc_bus_pkg::bus_data_t data,
                                output soc_bus_pkg::bus_data_t mask);
        if (to_bios(a)) begin
            data = bios_m[int'(a) % bios_words];
            mask = lane_mask(bios_known[int'(a) % bios_words]);
        end else begin
            data = ram_m[int'(a) % ram_words];
            mask = lane_mask(ram_known[int'(a) % ram_words]);
        end
    endtask

    task automatic model_write(input soc_bus_pkg::word_addr_t a,
                               input soc_bus_pkg::bus_data_t d, input soc_bus_pkg::bytesel_t sel);
        int i;
        if (to_bios(a)) begin
            i = int'(a) % bios_words;
            if (sel[0]) bios_m[i][7:0] = d[7:0];
            if (sel[1]) bios_m[i][15:8] = d[15:8];
            bios_known[i] = bios_known[i] | sel;
        end else begin
            i = int'(a) % ram_words;
            if (sel[0]) ram_m[i][7:0] = d[7:0];
            if (sel[1]) ram_m[i][15:8] = d[15:8];
            ram_known[i] = ram_known[i] | sel;
        end
    endtask

    // One data bus transfer, held until its ack
    task automatic data_xfer(input soc_bus_pkg::word_addr_t a, input soc_bus_pkg::bus_data_t d,
                             input logic wr, input soc_bus_pkg::bytesel_t sel, input logic io_flag,
                             output soc_bus_pkg::bus_data_t rd);
        @(posedge sys_clk);
        #5;
        data_addr = a;
        data_wdata = d;
        data_wr_en = wr;
        data_bytesel = sel;
        io = io_flag;
        data_access = 1'b1;
        do
            @(negedge sys_clk);
        while (!data_ack);
        rd = data_rdata;
        @(posedge sys_clk);
        #5;
        data_access = 1'b0;
    endtask

    task automatic mem_write(input soc_bus_pkg::word_addr_t a, input soc_bus_pkg::bus_data_t d,
                             input soc_bus_pkg::bytesel_t sel);
        soc_bus_pkg::bus_data_t rd;
        data_xfer(a, d, 1'b1, sel, 1'b0, rd);
        model_write(a, d, sel);
    endtask

    task automatic mem_read_check(input string name, input soc_bus_pkg::word_addr_t a);
        soc_bus_pkg::bus_data_t rd;
        soc_bus_pkg::bus_data_t exp;
        soc_bus_pkg::bus_data_t mask;
        data_xfer(a, 16'h0, 1'b0, 2'b11, 1'b0, rd);
        model_lookup(a, exp, mask);
        check(name, exp & mask, rd & mask);            // Never-written lanes are unknown
    endtask

    task automatic io_write(input soc_bus_pkg::io_port_t port, input soc_bus_pkg::bus_data_t d,
                            input soc_bus_pkg::bytesel_t sel);
        soc_bus_pkg::bus_data_t rd;
        data_xfer(soc_bus_pkg::word_addr_t'(port[15:1]), d, 1'b1, sel, 1'b1, rd);
        if (sel[0] && port == soc_bus_pkg::leds_port)
            leds_m = d[num_leds-1:0];
        if (sel[0] && port == soc_bus_pkg::bios_ctrl_port)
            bios_en_m = d[0];
        check("leds_after_write", soc_bus_pkg::bus_data_t'(leds_m), soc_bus_pkg::bus_data_t'(leds));
    endtask

    task automatic io_read_check(input string name, input soc_bus_pkg::io_port_t port);
        soc_bus_pkg::bus_data_t rd;
        soc_bus_pkg::bus_data_t exp;
        data_xfer(soc_bus_pkg::word_addr_t'(port[15:1]), 16'h0, 1'b0, 2'b11, 1'b1, rd);
        if (port == soc_bus_pkg::leds_port)
            exp = soc_bus_pkg::bus_data_t'(leds_m);
        else if (port == soc_bus_pkg::bios_ctrl_port)
            exp = soc_bus_pkg::bus_data_t'(bios_en_m);
        else
            exp = 16'h0;                               // Default responder
        check(name, exp, rd);
    endtask

    task automatic instr_read_check(input soc_bus_pkg::word_addr_t a);
        soc_bus_pkg::bus_data_t rd;
        soc_bus_pkg::bus_data_t exp;
        soc_bus_pkg::bus_data_t mask;
        @(posedge sys_clk);
        #5;
        instr_addr = a;
        instr_access = 1'b1;
        do
            @(negedge sys_clk);
        while (!instr_ack);
        rd = instr_rdata;
        model_lookup(a, exp, mask);
        check("instr_read", exp & mask, rd & mask);
        @(posedge sys_clk);
        #5;
        instr_access = 1'b0;
    endtask

    initial begin
        soc_bus_pkg::word_addr_t a;
        soc_bus_pkg::io_port_t p;
        logic [31:0] r;
        reset = 1'b1;
        instr_addr = '0;
        instr_access = 1'b0;
        data_addr = '0;
        data_wdata = '0;
        data_access = 1'b0;
        data_wr_en = 1'b0;
        data_bytesel = '0;
        io = 1'b0;
        leds_m = '0;
        bios_en_m = 1'b1;
        foreach (ram_known[i]) ram_known[i] = '0;
        foreach (bios_known[i]) bios_known[i] = '0;
        repeat (3) @(posedge sys_clk);
        #5;
        reset = 1'b0;

        repeat (2) begin                               // Quiet bus after reset
            @(negedge sys_clk);
            check("reset_instr_ack", 16'h0, soc_bus_pkg::bus_data_t'(instr_ack));
            check("reset_data_ack", 16'h0, soc_bus_pkg::bus_data_t'(data_ack));
        end
        check("reset_leds", 16'h0, soc_bus_pkg::bus_data_t'(leds));
        io_read_check("reset_bios_ctrl", soc_bus_pkg::bios_ctrl_port);

        repeat (150) begin                             // RAM byte lanes
            a = rand_addr(1'b0);
            if (($random(seed) & 3) == 0)
                mem_read_check("ram_read", a);
            else
                mem_write(a, soc_bus_pkg::bus_data_t'($random(seed)),
                          soc_bus_pkg::bytesel_t'($random(seed)));
        end

        repeat (60) begin                              // BIOS window enabled
            a = rand_addr(1'b1);
            if (($random(seed) & 3) == 0)
                mem_read_check("bios_read", a);
            else
                mem_write(a, soc_bus_pkg::bus_data_t'($random(seed)),
                          soc_bus_pkg::bytesel_t'($random(seed)));
        end

        // Fetches and data traffic kept on disjoint words
        fork
            begin
                soc_bus_pkg::word_addr_t ia;
                repeat (100) begin
                    if ($random(seed) & 1) begin
                        ia = rand_addr(1'b1);
                    end else begin
                        ia = rand_addr(1'b0);
                        ia[6] = 1'b1;
                    end
                    instr_read_check(ia);
                end
            end
            begin
                soc_bus_pkg::word_addr_t da;
                repeat (100) begin
                    da = rand_addr(1'b0);
                    da[6] = 1'b0;
                    if ($random(seed) & 1)
                        mem_read_check("concurrent_data_read", da);
                    else
                        mem_write(da, soc_bus_pkg::bus_data_t'($random(seed)),
                                  soc_bus_pkg::bytesel_t'($random(seed)));
                end
            end
        join

        io_write(soc_bus_pkg::bios_ctrl_port, 16'h0, 2'b11);
        repeat (60) begin                              // Window now aliases into RAM
            a = rand_addr(1'b1);
            if (($random(seed) & 3) == 0)
                mem_read_check("bios_off_read", a);
            else
                mem_write(a, soc_bus_pkg::bus_data_t'($random(seed)),
                          soc_bus_pkg::bytesel_t'($random(seed)));
        end
        io_write(soc_bus_pkg::bios_ctrl_port, 16'h1, 2'b01);
        io_read_check("bios_ctrl_read", soc_bus_pkg::bios_ctrl_port);

        repeat (30) begin
            io_write(soc_bus_pkg::leds_port, soc_bus_pkg::bus_data_t'($random(seed)),
                     soc_bus_pkg::bytesel_t'($random(seed)));
            io_read_check("leds_read", soc_bus_pkg::leds_port);
        end

        repeat (40) begin
            r = $random(seed);
            p = {r[15:1], 1'b0};
            if (p == soc_bus_pkg::leds_port || p == soc_bus_pkg::bios_ctrl_port)
                p = 16'h0100;
            if (r[16])
                io_write(p, soc_bus_pkg::bus_data_t'($random(seed)), 2'b11);
            else
                io_read_check("unknown_port", p);
        end
        io_read_check("bios_ctrl_final", soc_bus_pkg::bios_ctrl_port);
        io_read_check("leds_final", soc_bus_pkg::leds_port);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
